// ==== Makefile ====
TOP = tb_systolic_mm

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qx "TEST PASS" sim.log || (echo "simulation did not pass, see sim.log" && exit 1)

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== src/array_feed_if.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

// loader to array link, all signals registered on the loader side
interface array_feed_if;

    sa_pkg::operand_t a_edge [`SA_DIM]; // one per row, left column
    sa_pkg::operand_t b_edge [`SA_DIM]; // one per column, top row
    logic             mac_en;
    logic             clear;

    modport loader (
        output a_edge,
        output b_edge,
        output mac_en,
        output clear
    );

    modport array (
        input a_edge,
        input b_edge,
        input mac_en,
        input clear
    );

endinterface

// ==== src/mac_cell.sv ====
`timescale 1ns/1ps

module mac_cell (
    input  logic             clk,
    input  logic             rst,
    input  sa_pkg::operand_t a_in,
    input  sa_pkg::operand_t b_in,
    input  logic             mac_en,
    input  logic             clear,
    output sa_pkg::operand_t a_out,
    output sa_pkg::operand_t b_out,
    output sa_pkg::acc_t     acc
);

    logic signed [2*$bits(sa_pkg::operand_t)-1:0] prod;

    assign prod = a_in * b_in; // full precision, signed

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            a_out <= a_in; // to the right
            b_out <= b_in; // downward
            if (mac_en) begin
                acc <= acc + sa_pkg::acc_t'(prod);
            end
        end
    end

endmodule

// ==== src/operand_loader.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module operand_loader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  sa_pkg::operand_t      in_data,
    input  sa_pkg::phase_t        phase,
    input  logic [`SA_STEP_W-1:0] step,
    array_feed_if.loader          feed
);

    localparam int ADDR_W = $clog2(`SA_DIM * `SA_DIM);

    sa_pkg::operand_t a_buf [`SA_DIM * `SA_DIM]; // row-major
    sa_pkg::operand_t b_buf [`SA_DIM * `SA_DIM]; // row-major
    sa_pkg::operand_t a_nxt [`SA_DIM];
    sa_pkg::operand_t b_nxt [`SA_DIM];
    logic             take_a;
    logic             take_b;

    // first beat lands while still in IDLE, step is 0 then
    assign take_a = in_valid && (phase == sa_pkg::IDLE || phase == sa_pkg::LOAD_A);
    assign take_b = in_valid && (phase == sa_pkg::LOAD_B);

    ////////////////////
    // operand buffers
    always_ff @(posedge clk) begin
        if (take_a) begin
            a_buf[step[ADDR_W-1:0]] <= in_data;
        end
        if (take_b) begin
            b_buf[step[ADDR_W-1:0]] <= in_data;
        end
    end

    ////////////////////
    // diagonal skew
    // row i gets A[i][step-i], column j gets B[step-j][j]
    always_comb begin
        int k;
        for (int i = 0; i < `SA_DIM; i++) begin
            k        = int'(step) - i;
            a_nxt[i] = '0;
            b_nxt[i] = '0;
            if (phase == sa_pkg::COMPUTE && k >= 0 && k < `SA_DIM) begin
                a_nxt[i] = a_buf[i * `SA_DIM + k];
                b_nxt[i] = b_buf[k * `SA_DIM + i];
            end
        end
    end

    // edges and controls all leave on the same edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `SA_DIM; i++) begin
                feed.a_edge[i] <= '0;
                feed.b_edge[i] <= '0;
            end
            feed.mac_en <= 1'b0;
            feed.clear  <= 1'b0;
        end else begin
            for (int i = 0; i < `SA_DIM; i++) begin
                feed.a_edge[i] <= a_nxt[i];
                feed.b_edge[i] <= b_nxt[i];
            end
            feed.mac_en <= (phase == sa_pkg::COMPUTE);
            feed.clear  <= (phase == sa_pkg::LOAD_A); // zeroes the grid before each job
        end
    end

endmodule

// ==== src/pe_array.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module pe_array (
    input  logic         clk,
    input  logic         rst,
    array_feed_if.array  feed,
    output sa_pkg::acc_t acc_grid [`SA_DIM * `SA_DIM]
);

    ////////////////////
    // operand mesh
    // a_mesh[i][j] enters cell (i,j) from the left
    // b_mesh[i][j] enters cell (i,j) from above
    sa_pkg::operand_t a_mesh [`SA_DIM][`SA_DIM + 1];
    sa_pkg::operand_t b_mesh [`SA_DIM + 1][`SA_DIM];

    genvar gi;
    genvar gj;

    generate
        for (gi = 0; gi < `SA_DIM; gi++) begin : g_edge
            assign a_mesh[gi][0] = feed.a_edge[gi]; // left column
            assign b_mesh[0][gi] = feed.b_edge[gi]; // top row
        end
    endgenerate

    ////////////////////
    // cell grid
    generate
        for (gi = 0; gi < `SA_DIM; gi++) begin : g_row
            for (gj = 0; gj < `SA_DIM; gj++) begin : g_col
                mac_cell mac_cell_inst (
                    .clk    (clk),
                    .rst    (rst),
                    .a_in   (a_mesh[gi][gj]),
                    .b_in   (b_mesh[gi][gj]),
                    .mac_en (feed.mac_en),
                    .clear  (feed.clear),
                    .a_out  (a_mesh[gi][gj + 1]),
                    .b_out  (b_mesh[gi + 1][gj]),
                    .acc    (acc_grid[gi * `SA_DIM + gj]) // C[i][j], row-major
                );
            end
        end
    endgenerate

    // mac_en and clear are broadcast, only operands ripple
    // cell (i,j) sees A[i][k] and B[k][j] on the same edge

endmodule

// ==== src/phase_sequencer.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module phase_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output sa_pkg::phase_t        phase,
    output logic [`SA_STEP_W-1:0] step,
    output logic                  busy,
    output logic                  done
);

    localparam logic [`SA_STEP_W-1:0] LAST_BEAT = `SA_STEP_W'(`SA_DIM * `SA_DIM - 1);
    localparam logic [`SA_STEP_W-1:0] LAST_CAL  = `SA_STEP_W'(`SA_CAL_CYCLES - 1);
    localparam logic [`SA_STEP_W-1:0] ONE       = `SA_STEP_W'(1);

    sa_pkg::phase_t        phase_nxt;
    logic [`SA_STEP_W-1:0] step_nxt;
    logic                  start;

    assign start = in_valid && (phase == sa_pkg::IDLE);

    ////////////////////
    // next phase and step
    always_comb begin
        phase_nxt = phase;
        step_nxt  = step;
        case (phase)
            sa_pkg::IDLE: begin
                if (in_valid) begin
                    phase_nxt = sa_pkg::LOAD_A;
                    step_nxt  = ONE; // this beat already went in as A[0]
                end
            end
            sa_pkg::LOAD_A: begin
                if (in_valid) begin
                    if (step == LAST_BEAT) begin
                        phase_nxt = sa_pkg::LOAD_B;
                        step_nxt  = '0;
                    end else begin
                        step_nxt = step + ONE;
                    end
                end
            end
            sa_pkg::LOAD_B: begin
                if (in_valid) begin
                    if (step == LAST_BEAT) begin
                        phase_nxt = sa_pkg::COMPUTE;
                        step_nxt  = '0;
                    end else begin
                        step_nxt = step + ONE;
                    end
                end
            end
            sa_pkg::COMPUTE: begin
                if (step == LAST_CAL) begin
                    phase_nxt = sa_pkg::DRAIN;
                    step_nxt  = '0;
                end else begin
                    step_nxt = step + ONE; // strobes ignored here
                end
            end
            sa_pkg::DRAIN: begin
                if (step == LAST_BEAT) begin
                    phase_nxt = sa_pkg::IDLE;
                    step_nxt  = '0;
                end else begin
                    step_nxt = step + ONE;
                end
            end
            default: begin
                phase_nxt = sa_pkg::IDLE;
                step_nxt  = '0;
            end
        endcase
    end

    ////////////////////
    // state and status flags
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase <= sa_pkg::IDLE;
            step  <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            phase <= phase_nxt;
            step  <= step_nxt;
            done  <= (phase == sa_pkg::DRAIN) && (step == LAST_BEAT); // lines up with 16th result
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// ==== src/result_drain.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module result_drain (
    input  logic                  clk,
    input  logic                  rst,
    input  sa_pkg::phase_t        phase,
    input  logic [`SA_STEP_W-1:0] step,
    input  sa_pkg::acc_t          acc_grid [`SA_DIM * `SA_DIM],
    output logic                  out_valid,
    output sa_pkg::operand_t      out_data
);

    localparam int IDX_W = $clog2(`SA_DIM * `SA_DIM);

    sa_pkg::acc_t picked;
    sa_pkg::acc_t scaled;
    logic         draining;

    assign draining = (phase == sa_pkg::DRAIN);

    ////////////////////
    // select and scale
    assign picked = acc_grid[step[IDX_W-1:0]]; // row-major, step counts results
    assign scaled = picked >>> `SA_FRAC_W;     // drop fraction, keep sign

    ////////////////////
    // output stage
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= draining;
        end
    end

    // low bits only, overflow wraps
    always_ff @(posedge clk) begin
        if (draining) begin
            out_data <= sa_pkg::operand_t'(scaled);
        end
    end

endmodule

// ==== src/sa_pkg.sv ====
`include "sa_settings.svh"

package sa_pkg;

    ////////////////////
    // data types

    // matrix element, shared by A, B and C
    typedef logic signed [`SA_DATA_W-1:0] operand_t;

    // per-cell running sum
    typedef logic signed [`SA_ACC_W-1:0] acc_t;

    ////////////////////
    // job phases

    typedef enum logic [2:0] {
        IDLE,    // waiting for the first A beat
        LOAD_A,  // A beats, row-major
        LOAD_B,  // B beats, row-major
        COMPUTE, // wavefront through the array
        DRAIN    // one result per cycle
    } phase_t;

endpackage

// ==== src/sa_settings.svh ====
`ifndef SA_SETTINGS_SVH
`define SA_SETTINGS_SVH

////////////////////
// array geometry
`define SA_DIM 4

////////////////////
// number formats, Q4.4 operands
`define SA_DATA_W 8
`define SA_FRAC_W 4
`define SA_ACC_W 20 // four 16-bit products plus growth

////////////////////
// sequencing
// wavefront needs 3*dim-2 cycles, two more for margin
`define SA_CAL_CYCLES 12
`define SA_STEP_W 5

`endif

// ==== src/systolic_mm_top.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module systolic_mm_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  sa_pkg::operand_t in_data,
    output logic             out_valid,
    output sa_pkg::operand_t out_data,
    output logic             busy,
    output logic             done
);

    sa_pkg::phase_t        phase;
    logic [`SA_STEP_W-1:0] step;
    sa_pkg::acc_t          acc_grid [`SA_DIM * `SA_DIM];

    array_feed_if feed_if ();

    ////////////////////
    // control
    phase_sequencer phase_sequencer_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .phase    (phase),
        .step     (step),
        .busy     (busy),
        .done     (done)
    );

    ////////////////////
    // datapath
    operand_loader operand_loader_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .phase    (phase),
        .step     (step),
        .feed     (feed_if.loader)
    );

    pe_array pe_array_inst (
        .clk      (clk),
        .rst      (rst),
        .feed     (feed_if.array),
        .acc_grid (acc_grid)
    );

    result_drain result_drain_inst (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .step      (step),
        .acc_grid  (acc_grid),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== testbench/tb_systolic_mm.sv ====
`timescale 1ns/1ps
`include "sa_settings.svh"

module tb_systolic_mm;

    localparam int N_ELEM     = `SA_DIM * `SA_DIM;
    localparam int NUM_TESTS  = 5;
    localparam int JOB_BUDGET = 32 + `SA_CAL_CYCLES + 40; // cycles per test

    logic             clk;
    logic             rst;
    logic             in_valid;
    sa_pkg::operand_t in_data;
    logic             out_valid;
    sa_pkg::operand_t out_data;
    logic             busy;
    logic             done;

    sa_pkg::operand_t mat_a    [N_ELEM]; // row-major
    sa_pkg::operand_t mat_b    [N_ELEM];
    sa_pkg::operand_t expected [N_ELEM];
    sa_pkg::operand_t results  [$];      // out_data in arrival order

    logic [31:0] rng_state    = 32'haa0e83bd;
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          jobs_sent    = 0;
    int          done_count;
    int          valid_run;              // consecutive out_valid cycles so far

    systolic_mm_top systolic_mm_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // helpers
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic void note_protocol_error(input string what);
        error_count++;
        $display("protocol error at %0t ns: %s", $time, what);
    endfunction

    function automatic void expect_low(input string name, input logic value);
        assert (value == 1'b0)
        else begin
            error_count++;
            $display("[ERROR] %s expected 0x0 actual 0x%0h", name, value);
        end
    endfunction

    function automatic void fill_random();
        logic [31:0] r;
        for (int n = 0; n < N_ELEM; n++) begin
            r        = next_rand();
            mat_a[n] = r[31:24];
            mat_b[n] = r[23:16];
        end
    endfunction

    // reference: full-width signed dot product, then Q4.4 rescale
    function automatic void build_expected();
        int sum;
        for (int i = 0; i < `SA_DIM; i++) begin
            for (int j = 0; j < `SA_DIM; j++) begin
                sum = 0;
                for (int k = 0; k < `SA_DIM; k++) begin
                    sum = sum + int'(mat_a[i * `SA_DIM + k]) * int'(mat_b[k * `SA_DIM + j]);
                end
                expected[i * `SA_DIM + j] = sa_pkg::operand_t'(sum >>> `SA_FRAC_W);
            end
        end
    endfunction

    function automatic void check_results();
        assert (results.size() == N_ELEM)
        else begin
            error_count++;
            $display("job returned %0d results instead of %0d", results.size(), N_ELEM);
        end
        for (int n = 0; n < N_ELEM && n < results.size(); n++) begin
            assert (results[n] == expected[n])
            else begin
                error_count++;
                $display("[ERROR] out_data[%0d] expected 0x%02h actual 0x%02h",
                         n, expected[n], results[n]);
            end
        end
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    ////////////////////
    // stimulus
    task automatic send_beat(input sa_pkg::operand_t value, input int gap);
        repeat (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= value;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!done);
        @(negedge clk); // 16th result is collected on the edge in between
    endtask

    // A then B, optional junk strobes while computing and draining
    task automatic run_job(input int max_gap, input bit strobe_late);
        logic [31:0] r;
        int          gap;
        results.delete();
        jobs_sent++;
        for (int n = 0; n < 2 * N_ELEM; n++) begin
            r   = next_rand();
            gap = int'(r[23:16]) % (max_gap + 1);
            if (n < N_ELEM) begin
                send_beat(mat_a[n], gap);
            end else begin
                send_beat(mat_b[n - N_ELEM], gap);
            end
        end
        if (strobe_late) begin
            repeat (20) begin // ends well before DRAIN is over
                r = next_rand();
                @(posedge clk);
                in_valid <= 1'b1;
                in_data  <= r[31:24];
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait_done();
    endtask

    ////////////////////
    // collector and run length
    always @(posedge clk) begin
        if (!rst) begin
            valid_run  <= 0;
            done_count <= 0;
        end else begin
            if (out_valid) begin
                results.push_back(out_data);
                valid_run <= valid_run + 1;
            end else begin
                valid_run <= 0;
            end
            if (done) begin
                done_count <= done_count + 1;
            end
        end
    end

    ////////////////////
    // protocol checks
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst)
        !busy |-> (!out_valid && !done))
        else note_protocol_error("out_valid or done high while busy is low");

    a_busy_start: assert property (@(posedge clk) disable iff (!rst)
        $rose(busy) |-> $past(in_valid))
        else note_protocol_error("busy rose without an input strobe");

    a_done_last: assert property (@(posedge clk) disable iff (!rst)
        done |-> (out_valid && valid_run == N_ELEM - 1))
        else note_protocol_error("done did not come with the 16th consecutive result");

    a_valid_end: assert property (@(posedge clk) disable iff (!rst)
        $fell(out_valid) |-> $past(done))
        else note_protocol_error("out_valid dropped before done");

    a_busy_end: assert property (@(posedge clk) disable iff (!rst)
        done |=> !busy)
        else note_protocol_error("busy still high after done");

    ////////////////////
    // main sequence
    initial begin
        int errs;
        rst      = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        errs = error_count;
        repeat (8) begin
            @(negedge clk);
            expect_low("out_valid", out_valid);
            expect_low("done", done);
            expect_low("busy", busy);
        end
        finish_test("reset state", errs);

        errs = error_count;
        fill_random();
        for (int n = 0; n < N_ELEM; n++) begin
            mat_a[n]    = (n / `SA_DIM == n % `SA_DIM) ? 8'sh10 : 8'sh00; // 1.0 on diagonal
            expected[n] = mat_b[n];
        end
        run_job(0, 1'b0);
        check_results();
        finish_test("identity times B", errs);

        errs = error_count;
        repeat (2) begin
            fill_random();
            build_expected();
            run_job(1, 1'b0);
            check_results();
        end
        finish_test("random operands with gaps", errs);

        errs = error_count;
        repeat (2) begin // back to back, second one also proves the clear
            fill_random();
            build_expected();
            run_job(0, 1'b1);
            check_results();
        end
        finish_test("ignored strobes, back-to-back jobs", errs);

        errs = error_count;
        assert (done_count == jobs_sent)
        else begin
            error_count++;
            $display("[ERROR] done pulses expected 0x%0h actual 0x%0h", jobs_sent, done_count);
        end
        expect_low("busy", busy);
        finish_test("job framing", errs);

        $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (10 + NUM_TESTS * JOB_BUDGET) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 10 + NUM_TESTS * JOB_BUDGET);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/sa_pkg.sv
src/array_feed_if.sv
src/phase_sequencer.sv
src/operand_loader.sv
src/mac_cell.sv
src/pe_array.sv
src/result_drain.sv
src/systolic_mm_top.sv
testbench/tb_systolic_mm.sv
